// ==== fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

	localparam logic [31:0] reset_pc = 32'h3000_0000; // Boot flash, first fetch
	localparam logic [31:0] cache_base = 32'ha000_0000; // SDRAM start
	localparam logic [31:0] cache_limit = 32'ha200_0000; // First address past SDRAM
	localparam logic [31:0] pc_step = 32'd4; // One instruction

	localparam logic [1:0] burst_fixed = 2'b00; // Single beat, bypass reads
	localparam logic [1:0] burst_incr = 2'b01; // Line fill bursts

	localparam logic [1:0] resp_okay = 2'b00;

	// Read address channel
	typedef struct packed {
		logic [31:0] addr;
		logic [1:0] burst;
		logic [3:0] len; // Beats minus one
	} mem_ar_t;

	// Read data channel
	typedef struct packed {
		logic [31:0] data;
		logic [1:0] resp;
		logic last; // Final beat of the burst
	} mem_r_t;

	// One fill word from ifu into the cache
	typedef struct packed {
		logic [31:0] line_addr; // Line aligned
		logic [2:0] offset; // Word within the line
		logic [31:0] data;
	} fill_beat_t;

	// Handed on to decode
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
		logic fault; // Memory answered with an error
	} fetch_out_t;

	// Mispredict or jump from the back end
	typedef struct packed {
		logic valid; // Single cycle pulse
		logic [31:0] target;
	} redirect_t;

endpackage

`default_nettype wire

// ==== ifu.sv ====
`timescale 1ns/1ns
`default_nettype none

module ifu #(
	parameter int line_words = 8
) (
	input wire clock,
	input wire reset,
	output fetch_pkg::mem_ar_t mem_ar,
	output logic mem_ar_valid,
	input wire mem_ar_ready,
	input wire fetch_pkg::mem_r_t mem_r,
	input wire mem_r_valid,
	output logic lookup_valid,
	output logic [31:0] lookup_addr,
	input wire hit,
	input wire [31:0] hit_inst,
	output fetch_pkg::fill_beat_t fill,
	output logic fill_valid,
	input wire fetch_pkg::redirect_t redirect,
	output fetch_pkg::fetch_out_t out,
	output logic out_valid,
	input wire out_ready
);

	localparam int offset_w = $clog2(line_words); // Word offset bits in a line
	localparam logic [31:0] line_mask = 32'(line_words * 4) - 32'd1; // Byte offset bits

	typedef enum logic [2:0] {
		idle, // Picks cached or bypass path, issues the lookup
		lookup, // Cache answer arrives
		miss_request,
		miss_wait,
		bypass_request,
		bypass_wait,
		hold // out_valid high until decode takes it
	} state_t;

	state_t state, state_next;
	logic [31:0] pc, pc_next;
	logic pending_valid; // Redirect seen while a read was outstanding
	logic [31:0] pending_target;
	logic [offset_w-1:0] beat_count; // Word offset of the next fill beat
	logic fill_err; // An earlier beat of this line came back with an error
	fetch_pkg::fetch_out_t out_q;

	logic mem_r_ready;
	logic cacheable;
	logic beat;
	logic beat_err;
	logic word_match;
	logic outstanding;
	logic burst_done;
	logic redirect_now;
	logic [31:0] redirect_pc;
	logic [31:0] line_addr;

	assign mem_r_ready = 1'b1; // Fetch always sinks read data
	assign cacheable = pc >= fetch_pkg::cache_base && pc < fetch_pkg::cache_limit;
	assign beat = mem_r_valid && mem_r_ready;
	assign beat_err = mem_r.resp != fetch_pkg::resp_okay;
	assign word_match = beat_count == pc[offset_w+1:2]; // Beat carries the wanted word
	assign line_addr = pc & ~line_mask;

	assign outstanding = state == miss_request || state == miss_wait ||
		state == bypass_request || state == bypass_wait;
	assign burst_done = (state == miss_wait && beat && mem_r.last) ||
		(state == bypass_wait && beat);

	// A redirect in the closing cycle wins over the remembered one
	assign redirect_now = redirect.valid || pending_valid;
	assign redirect_pc = redirect.valid ? redirect.target : pending_target;

	assign lookup_valid = state == idle && cacheable;
	assign lookup_addr = pc;

	assign mem_ar_valid = state == miss_request || state == bypass_request;
	assign mem_ar.addr = state == miss_request ? line_addr : pc; // Stable, pc frozen here
	assign mem_ar.burst = state == miss_request ? fetch_pkg::burst_incr : fetch_pkg::burst_fixed;
	assign mem_ar.len = state == miss_request ? 4'(line_words - 1) : 4'd0;

	// Once a beat fails the rest of the line is kept out, so it never turns valid
	assign fill_valid = state == miss_wait && beat && !fill_err && !beat_err;
	assign fill.line_addr = line_addr;
	assign fill.offset = 3'(beat_count);
	assign fill.data = mem_r.data;

	assign out = out_q;
	assign out_valid = state == hold;

	always_comb begin
		state_next = state;
		pc_next = pc;
		case (state)
			idle: begin
				if (redirect.valid) begin
					pc_next = redirect.target; // Answer to the old lookup is ignored
				end else if (cacheable) begin
					state_next = lookup;
				end else begin
					state_next = bypass_request;
				end
			end
			lookup: begin
				if (redirect.valid) begin
					pc_next = redirect.target;
					state_next = idle;
				end else if (hit) begin
					state_next = hold;
				end else begin
					state_next = miss_request;
				end
			end
			miss_request: begin
				if (mem_ar_ready) state_next = miss_wait;
			end
			bypass_request: begin
				if (mem_ar_ready) state_next = bypass_wait;
			end
			miss_wait, bypass_wait: begin
				if (burst_done) begin
					if (redirect_now) begin
						pc_next = redirect_pc; // Wrong path word dropped
						state_next = idle;
					end else begin
						state_next = hold;
					end
				end
			end
			hold: begin
				if (redirect.valid) begin
					pc_next = redirect.target; // Flush regardless of out_ready
					state_next = idle;
				end else if (out_ready) begin
					pc_next = pc + fetch_pkg::pc_step;
					state_next = idle;
				end
			end
			default: state_next = idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			pc <= fetch_pkg::reset_pc;
			pending_valid <= 1'b0;
			beat_count <= '0;
			fill_err <= 1'b0;
		end else begin
			state <= state_next;
			pc <= pc_next;
			if (burst_done) begin
				pending_valid <= 1'b0;
			end else if (redirect.valid && outstanding) begin
				pending_valid <= 1'b1; // Read must finish first
			end
			if (state == miss_request && mem_ar_ready) begin
				beat_count <= '0;
				fill_err <= 1'b0;
			end else if (state == miss_wait && beat) begin
				beat_count <= beat_count + 1'b1;
				if (beat_err) fill_err <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (redirect.valid) pending_target <= redirect.target; // Latest redirect kept
		if (state == lookup && hit) begin
			out_q <= '{pc: pc, inst: hit_inst, fault: 1'b0};
		end
		if (state == miss_wait && beat && word_match) begin
			out_q <= '{pc: pc, inst: mem_r.data, fault: beat_err};
		end
		if (state == bypass_wait && beat) begin
			out_q <= '{pc: pc, inst: mem_r.data, fault: beat_err};
		end
	end

	// Read request must not change or vanish before the memory takes it
	assert property (@(posedge clock) disable iff (reset)
		mem_ar_valid && !mem_ar_ready |=> mem_ar_valid && $stable(mem_ar));

	// Lookup, fill and output each own a separate phase
	assert property (@(posedge clock) disable iff (reset)
		lookup_valid |=> !out_valid && !fill_valid);

endmodule

`default_nettype wire

// ==== icache.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache #(
	parameter int line_words = 8,
	parameter int cache_lines = 16
) (
	input wire clock,
	input wire reset,
	input wire lookup_valid,
	input wire [31:0] lookup_addr,
	output logic hit,
	output logic [31:0] hit_inst,
	input wire fetch_pkg::fill_beat_t fill,
	input wire fill_valid
);

	localparam int offset_w = $clog2(line_words);
	localparam int index_w = $clog2(cache_lines);
	localparam int tag_w = 32 - 2 - offset_w - index_w; // Rest above index and offset

	logic [cache_lines-1:0] line_valid;
	logic [tag_w-1:0] tag_mem [cache_lines];
	logic [31:0] data_mem [cache_lines * line_words]; // Index and offset concatenated

	logic lookup_valid_q;
	logic [31:0] lookup_addr_q;

	logic [tag_w-1:0] lookup_tag;
	logic [index_w-1:0] lookup_index;
	logic [offset_w-1:0] lookup_offset;

	logic [tag_w-1:0] fill_tag;
	logic [index_w-1:0] fill_index;
	logic [offset_w-1:0] fill_offset;
	logic fill_first;
	logic fill_last;

	// Address split of the registered lookup
	assign lookup_tag = lookup_addr_q[31 -: tag_w];
	assign lookup_index = lookup_addr_q[offset_w+2 +: index_w];
	assign lookup_offset = lookup_addr_q[2 +: offset_w];

	assign fill_tag = fill.line_addr[31 -: tag_w];
	assign fill_index = fill.line_addr[offset_w+2 +: index_w];
	assign fill_offset = fill.offset[offset_w-1:0];
	assign fill_first = fill_offset == '0;
	assign fill_last = fill_offset == offset_w'(line_words - 1); // Beat marked last

	// Answer one cycle after the request
	assign hit = lookup_valid_q && line_valid[lookup_index] &&
		tag_mem[lookup_index] == lookup_tag;
	assign hit_inst = data_mem[{lookup_index, lookup_offset}];

	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid <= '0;
			lookup_valid_q <= 1'b0;
		end else begin
			lookup_valid_q <= lookup_valid;
			if (fill_valid && fill_last) begin
				line_valid[fill_index] <= 1'b1; // Whole line present
			end else if (fill_valid && fill_first) begin
				line_valid[fill_index] <= 1'b0; // Old line overwritten from here on
			end
		end
	end

	always_ff @(posedge clock) begin
		if (lookup_valid) lookup_addr_q <= lookup_addr;
		if (fill_valid) data_mem[{fill_index, fill_offset}] <= fill.data;
		if (fill_valid && fill_last) tag_mem[fill_index] <= fill_tag;
	end

	// A hit only ever answers a lookup from the cycle before
	assert property (@(posedge clock) disable iff (reset)
		!lookup_valid |=> !hit);

endmodule

`default_nettype wire

// ==== fetch_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_top #(
	parameter int line_words = 8, // Words per line, power of two
	parameter int cache_lines = 16 // Lines in the cache, power of two
) (
	input wire clock,
	input wire reset,
	output fetch_pkg::mem_ar_t mem_ar,
	output logic mem_ar_valid,
	input wire mem_ar_ready,
	input wire fetch_pkg::mem_r_t mem_r,
	input wire mem_r_valid,
	input wire fetch_pkg::redirect_t redirect,
	output fetch_pkg::fetch_out_t out,
	output logic out_valid,
	input wire out_ready
);

	logic lookup_valid;
	logic [31:0] lookup_addr;
	logic hit;
	logic [31:0] hit_inst;
	fetch_pkg::fill_beat_t fill; // Burst beats into the data array
	logic fill_valid;

	ifu #(
		.line_words(line_words)
	) i_ifu (
		.clock(clock),
		.reset(reset),
		.mem_ar(mem_ar),
		.mem_ar_valid(mem_ar_valid),
		.mem_ar_ready(mem_ar_ready),
		.mem_r(mem_r),
		.mem_r_valid(mem_r_valid),
		.lookup_valid(lookup_valid),
		.lookup_addr(lookup_addr),
		.hit(hit),
		.hit_inst(hit_inst),
		.fill(fill),
		.fill_valid(fill_valid),
		.redirect(redirect),
		.out(out),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	icache #(
		.line_words(line_words),
		.cache_lines(cache_lines)
	) i_icache (
		.clock(clock),
		.reset(reset),
		.lookup_valid(lookup_valid),
		.lookup_addr(lookup_addr),
		.hit(hit),
		.hit_inst(hit_inst),
		.fill(fill),
		.fill_valid(fill_valid)
	);

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model #(
	parameter logic [31:0] pattern = 32'h0, // Image word is its address XOR this
	parameter int seed_init = 1
) (
	input wire clock,
	input wire reset,
	input wire fetch_pkg::mem_ar_t mem_ar,
	input wire mem_ar_valid,
	output logic mem_ar_ready,
	output fetch_pkg::mem_r_t mem_r,
	output logic mem_r_valid,
	input wire [1:0] max_gap, // Upper bound of idle cycles before a beat
	input wire [31:0] err_addr // This word comes back with an error response
);

	localparam logic [1:0] resp_error = 2'b10;

	int seed;
	int gap_left;
	int beats_left;
	logic busy; // Burst accepted, beats still to send
	logic in_reset;
	logic incr;
	logic [1:0] gap_max;
	logic [31:0] bad_addr;
	logic [31:0] addr; // Word of the next beat

	function automatic int draw_gap();
		if (gap_max == 2'd0) return 0;
		return int'($unsigned($random(seed)) % (32'(gap_max) + 32'd1));
	endfunction

	initial begin
		seed = seed_init;
		busy = 1'b0;
		mem_ar_ready = 1'b0;
		mem_r_valid = 1'b0;
		mem_r = '0;
		forever begin
			@(posedge clock);
			in_reset = reset; // Config taken on the edge, the testbench moves it 1 ns later
			gap_max = max_gap;
			bad_addr = err_addr;
			#1;
			mem_r_valid = 1'b0;
			if (in_reset) begin
				busy = 1'b0;
				mem_ar_ready = 1'b0;
			end else if (!busy) begin
				mem_ar_ready = 1'b1;
				if (mem_ar_valid) begin // Handshake at the coming edge
					addr = mem_ar.addr;
					incr = mem_ar.burst == fetch_pkg::burst_incr;
					beats_left = int'(mem_ar.len) + 1;
					gap_left = draw_gap();
					busy = 1'b1;
				end
			end else begin
				mem_ar_ready = 1'b0;
				if (gap_left > 0) begin
					gap_left--;
				end else begin
					mem_r_valid = 1'b1;
					mem_r.data = addr ^ pattern;
					mem_r.resp = addr == bad_addr ? resp_error : fetch_pkg::resp_okay;
					mem_r.last = beats_left == 1;
					if (incr) addr = addr + 32'd4; // Fixed bursts stay put
					beats_left--;
					gap_left = draw_gap();
					busy = beats_left > 0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_fetch_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_top;

	localparam logic [31:0] image_pattern = 32'h5a3c_96e1;
	localparam int seed_init = 32'he4fad266;
	localparam int line_words = 8;
	localparam int timeout_cycles = 2000;
	localparam logic [31:0] line_a = fetch_pkg::cache_base + 32'h400; // Same index as base
	localparam logic [31:0] line_b = fetch_pkg::cache_base + 32'h40; // Cached in test 2
	localparam logic [31:0] line_f = fetch_pkg::cache_base + 32'h2000;

	logic clock = 1'b0;
	logic reset;
	fetch_pkg::mem_ar_t mem_ar;
	logic mem_ar_valid;
	logic mem_ar_ready;
	fetch_pkg::mem_r_t mem_r;
	logic mem_r_valid;
	fetch_pkg::redirect_t redirect;
	fetch_pkg::fetch_out_t out;
	logic out_valid;
	logic out_ready;
	logic [1:0] max_gap;
	logic [31:0] err_addr;

	int seed = seed_init;
	int errors = 0;
	int checks = 0;
	int test_errors = 0; // Error count when the current test began
	int delivered; // Handshakes since the last redirect
	int requests; // Read requests since the last redirect
	logic [31:0] expected_pc = fetch_pkg::reset_pc;
	logic was_held = 1'b0; // out stalled last cycle
	logic was_flushed = 1'b0; // out_valid met a redirect last cycle
	fetch_pkg::fetch_out_t held;

	always #2 clock = ~clock;

	fetch_top #(
		.line_words(line_words),
		.cache_lines(16)
	) i_dut (
		.clock(clock),
		.reset(reset),
		.mem_ar(mem_ar),
		.mem_ar_valid(mem_ar_valid),
		.mem_ar_ready(mem_ar_ready),
		.mem_r(mem_r),
		.mem_r_valid(mem_r_valid),
		.redirect(redirect),
		.out(out),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	tb_mem_model #(
		.pattern(image_pattern),
		.seed_init(seed_init)
	) i_mem (
		.clock(clock),
		.reset(reset),
		.mem_ar(mem_ar),
		.mem_ar_valid(mem_ar_valid),
		.mem_ar_ready(mem_ar_ready),
		.mem_r(mem_r),
		.mem_r_valid(mem_r_valid),
		.max_gap(max_gap),
		.err_addr(err_addr)
	);

	// Expected decode word for a pc
	function automatic fetch_pkg::fetch_out_t expected_fetch(input logic [31:0] pc);
		fetch_pkg::fetch_out_t result;
		result.pc = pc;
		result.inst = pc ^ image_pattern; // Image word at its own address
		result.fault = pc == err_addr;
		return result;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t: no %s within %0d cycles", $time, what, timeout_cycles);
		$display("CHECKS FAILED");
		$finish;
	endtask

	task automatic finish_test(input string name);
		$display("Test %s done, %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	// One cycle of checks, taken 1 ns before the next edge
	task automatic watch_cycle();
		fetch_pkg::fetch_out_t want;
		if (mem_ar_valid && mem_ar_ready) begin
			requests++;
			if (mem_ar.addr >= fetch_pkg::cache_base && mem_ar.addr < fetch_pkg::cache_limit) begin
				check_value("mem_ar.burst", 32'(mem_ar.burst), 32'(fetch_pkg::burst_incr));
				check_value("mem_ar.len", 32'(mem_ar.len), 32'(line_words - 1));
				check_value("mem_ar.addr line offset", mem_ar.addr & 32'(line_words * 4 - 1),
					32'd0);
			end else begin
				check_value("mem_ar.burst", 32'(mem_ar.burst), 32'(fetch_pkg::burst_fixed));
				check_value("mem_ar.len", 32'(mem_ar.len), 32'd0);
			end
		end
		if (was_held) begin // Stalled output must not move
			check_value("out_valid", 32'(out_valid), 32'd1);
			check_value("out.pc", out.pc, held.pc);
			check_value("out.inst", out.inst, held.inst);
			check_value("out.fault", 32'(out.fault), 32'(held.fault));
		end
		if (was_flushed) check_value("out_valid", 32'(out_valid), 32'd0);
		if (out_valid && out_ready && !redirect.valid) begin
			want = expected_fetch(expected_pc);
			check_value("out.pc", out.pc, want.pc);
			check_value("out.inst", out.inst, want.inst);
			check_value("out.fault", 32'(out.fault), 32'(want.fault));
			expected_pc = expected_pc + 32'd4;
			delivered++;
		end
		if (redirect.valid) expected_pc = redirect.target;
		was_held = out_valid && !out_ready && !redirect.valid;
		was_flushed = out_valid && redirect.valid;
		held = out;
	endtask

	always begin
		@(posedge clock);
		#3;
		if (!reset) watch_cycle();
	end

	task automatic wait_out_valid();
		int cycles;
		for (cycles = 0; cycles < timeout_cycles; cycles++) begin
			if (out_valid) return;
			@(posedge clock);
			#1;
		end
		report_timeout("out_valid");
	endtask

	task automatic wait_request();
		int cycles;
		for (cycles = 0; cycles < timeout_cycles; cycles++) begin
			@(posedge clock);
			#1;
			if (requests > 0) return;
		end
		report_timeout("read request");
	endtask

	// Drives out_ready until n instructions went out, then stalls decode
	task automatic wait_deliveries(input int n, input logic random_ready);
		int cycles;
		for (cycles = 0; cycles < timeout_cycles; cycles++) begin
			@(posedge clock);
			#1;
			if (delivered >= n) begin
				out_ready = 1'b0;
				return;
			end
			out_ready = random_ready ? 1'($random(seed)) : 1'b1;
		end
		report_timeout("delivered instructions");
	endtask

	task automatic pulse_redirect(input logic [31:0] pc);
		redirect = '{valid: 1'b1, target: pc};
		delivered = 0;
		requests = 0;
		@(posedge clock);
		#1;
		redirect.valid = 1'b0;
	endtask

	initial begin
		reset = 1'b1;
		out_ready = 1'b0;
		redirect = '0;
		max_gap = 2'd0;
		err_addr = 32'd0; // Never fetched
		delivered = 0;
		requests = 0;
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;

		max_gap = 2'd2;
		wait_deliveries(20, 1'b0);
		check_value("bypass requests", 32'(requests), 32'd20);
		finish_test("bypass fetch");

		wait_out_valid();
		pulse_redirect(fetch_pkg::cache_base);
		wait_deliveries(64, 1'b0);
		check_value("line requests", 32'(requests), 32'(64 / line_words));
		finish_test("cached fetch");

		wait_out_valid();
		pulse_redirect(fetch_pkg::cache_base);
		wait_deliveries(64, 1'b0);
		check_value("hit requests", 32'(requests), 32'd0);
		finish_test("hit reuse");

		max_gap = 2'd3;
		wait_out_valid();
		pulse_redirect(line_a);
		wait_request(); // Burst for line_a now running
		pulse_redirect(line_b);
		wait_deliveries(4, 1'b0);
		check_value("requests after redirect", 32'(requests), 32'd0);
		wait_out_valid();
		pulse_redirect(line_a);
		wait_deliveries(line_words, 1'b0);
		check_value("interrupted line requests", 32'(requests), 32'd0);
		finish_test("redirect mid-miss");

		max_gap = 2'd2;
		err_addr = line_f + 32'h8;
		wait_out_valid();
		pulse_redirect(line_f);
		wait_deliveries(3 * line_words, 1'b1);
		finish_test("back-pressure and faults");

		$display("Tests 5, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
fetch_pkg.sv
ifu.sv
icache.sv
fetch_top.sv
tb_mem_model.sv
tb_fetch_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
	-f flist.f --top-module tb_fetch_top -o tb_fetch_top

./obj_dir/tb_fetch_top | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi

echo "Simulation passed"
